/* Bender.yml */
package:
  name: rv32-single-cycle

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/cpuPkg.sv
      - hw/alu.sv
      - hw/regFile.sv
      - hw/decoder.sv
      - hw/dataMem.sv
      - hw/fetchUnit.sv
      - hw/runControl.sv
      - hw/cpuTop.sv
  - target: simulation
    include_dirs:
      - hw
      - sim
    files:
      - sim/cpuTb.sv

/* hw/alu.sv */
// Integer ALU
`timescale 1ns/10ps

module alu (
    input  cpuPkg::aluOp op,
    input  cpuPkg::word a,
    input  cpuPkg::word b,
    output cpuPkg::word result,
    output logic zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0];   // Low five bits only

    always_comb begin
        case (op)
            cpuPkg::opAdd:   result = a + b;
            cpuPkg::opSub:   result = a - b;
            cpuPkg::opAnd:   result = a & b;
            cpuPkg::opOr:    result = a | b;
            cpuPkg::opXor:   result = a ^ b;
            cpuPkg::opSlt:   result = {31'b0, $signed(a) < $signed(b)};   // Signed compare
            cpuPkg::opSll:   result = a << shamt;
            cpuPkg::opSrl:   result = a >> shamt;
            cpuPkg::opSra:   result = $signed(a) >>> shamt;
            cpuPkg::opPassB: result = b;
            default:         result = '0;
        endcase
    end

    // Branch equality test
    assign zero = (result == '0);

endmodule

/* hw/cpuPkg.sv */
// Core shared types
`include "cpu_params.svh"

package cpuPkg;

    typedef logic [`CPU_XLEN-1:0] word;   // Data and address
    typedef logic [4:0] regIdx;            // Register number

    // Host request of 47 bits
    typedef struct packed {
        logic [`CPU_APB_AW-1:0] paddr;
        logic psel;
        logic penable;
        logic pwrite;
        word pwdata;
    } apbReq;

    // Host response of 34 bits
    typedef struct packed {
        word prdata;
        logic pready;
        logic pslverr;
    } apbRsp;

    typedef enum logic [3:0] {
        opAdd, opSub, opAnd, opOr, opXor,
        opSlt, opSll, opSrl, opSra, opPassB   // PassB for lui
    } aluOp;

    // Matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {memByte, memHalf, memWord} memSize;

    typedef enum logic [1:0] {wbAluResult, wbMemData, wbLinkPc} wbSel;

    // Decoded control for one instruction
    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        memSize memSize;
        logic memUnsigned;      // lbu, lhu
        logic aluSrcImm;        // B operand from imm
        aluOp aluOp;
        wbSel wbSel;
        logic branch;
        logic branchNe;         // bne, else beq
        logic jump;
        logic halt;             // ecall
        word imm;
    } ctrlSig;

endpackage

/* hw/cpuTop.sv */
// Single-cycle core with host port
`timescale 1ns/10ps
`include "cpu_params.svh"

module cpuTop (
    input  logic clock,
    input  logic arstN,
    input  cpuPkg::apbReq apbIn,
    output cpuPkg::apbRsp apbOut
);

    localparam int IW = $clog2(`CPU_IMEM_WORDS);
    localparam int DW = $clog2(`CPU_DMEM_WORDS);

    cpuPkg::ctrlSig ctrl, ctrlMem;
    cpuPkg::word instr, pcNow, retired, progData, hostRdData;
    cpuPkg::word rd1, rd2, aluB, aluResult, memRdata, wbData;
    logic runEn, clearPc, progWe, zero;
    logic [IW-1:0] progIdx;
    logic [DW-1:0] hostRdIdx;

    runControl uRunControl (
        .clock(clock), .arstN(arstN), .apbIn(apbIn), .haltReq(ctrl.halt),
        .apbOut(apbOut), .runEn(runEn), .clearPc(clearPc), .progWe(progWe),
        .progIdx(progIdx), .progData(progData), .hostRdIdx(hostRdIdx),
        .retired(retired), .hostRdData(hostRdData)
    );

    fetchUnit #(.WORDS(`CPU_IMEM_WORDS)) uFetch (
        .clock(clock), .arstN(arstN), .runEn(runEn), .clearPc(clearPc),
        .progWe(progWe), .progIdx(progIdx), .progData(progData), .ctrl(ctrl),
        .zero(zero), .instr(instr), .pcNow(pcNow), .retired(retired)
    );

    decoder uDecoder (.instr(instr), .ctrl(ctrl));

    regFile uRegFile (
        .clock(clock), .arstN(arstN), .we(ctrl.regWrite & runEn),   // No writes while stopped
        .rs1(instr[19:15]), .rs2(instr[24:20]), .rd(instr[11:7]),
        .wd(wbData), .rd1(rd1), .rd2(rd2)
    );

    assign aluB = ctrl.aluSrcImm ? ctrl.imm : rd2;

    alu uAlu (.op(ctrl.aluOp), .a(rd1), .b(aluB), .result(aluResult), .zero(zero));

    // Store gated by run state
    always_comb begin
        ctrlMem = ctrl;
        ctrlMem.memWrite = ctrl.memWrite & runEn;
    end

    dataMem #(.WORDS(`CPU_DMEM_WORDS)) uDataMem (
        .clock(clock), .addr(aluResult), .wdata(rd2), .ctrl(ctrlMem),
        .hostRdIdx(hostRdIdx), .rdata(memRdata), .hostRdData(hostRdData)
    );

    // Write-back select
    always_comb begin
        case (ctrl.wbSel)
            cpuPkg::wbMemData: wbData = memRdata;
            cpuPkg::wbLinkPc:  wbData = pcNow + 32'd4;   // jal link
            default:           wbData = aluResult;
        endcase
    end

endmodule

/* hw/cpu_params.svh */
// Core sizing and host map
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath width
`define CPU_XLEN         32

// Memory depths in words
`define CPU_IMEM_WORDS   256
`define CPU_DMEM_WORDS   256

// APB byte address width
`define CPU_APB_AW       12

// Register offsets
`define CPU_ADDR_CTRL    'h000
`define CPU_ADDR_STATUS  'h004
`define CPU_ADDR_RETIRED 'h008

// Program window write-only and data window read-only
`define CPU_IMEM_BASE    'h400
`define CPU_DMEM_BASE    'h800

`endif

/* hw/dataMem.sv */
// Byte-lane data memory
`timescale 1ns/10ps
`include "cpu_params.svh"

module dataMem #(
    parameter int WORDS = `CPU_DMEM_WORDS
) (
    input  logic clock,
    input  cpuPkg::word addr,
    input  cpuPkg::word wdata,
    input  cpuPkg::ctrlSig ctrl,
    input  logic [$clog2(WORDS)-1:0] hostRdIdx,
    output cpuPkg::word rdata,
    output cpuPkg::word hostRdData
);

    localparam int IdxW = $clog2(WORDS);

    cpuPkg::word mem [WORDS];
    logic [IdxW-1:0] wordIdx;
    logic [3:0] laneEn;
    cpuPkg::word laneData, rawWord, loaded;
    logic [7:0] loadByte;
    logic [15:0] loadHalf;

    assign wordIdx = addr[IdxW+1:2];

    // Lane enables and replicated store data
    always_comb begin
        case (ctrl.memSize)
            cpuPkg::memByte: begin
                laneEn   = 4'b0001 << addr[1:0];
                laneData = {4{wdata[7:0]}};
            end
            cpuPkg::memHalf: begin
                laneEn   = addr[1] ? 4'b1100 : 4'b0011;
                laneData = {2{wdata[15:0]}};
            end
            default: begin
                laneEn   = 4'b1111;
                laneData = wdata;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (ctrl.memWrite) begin
            for (int i = 0; i < 4; i++) begin
                if (laneEn[i]) begin
                    mem[wordIdx][8*i +: 8] <= laneData[8*i +: 8];
                end
            end
        end
    end

    // Little-endian lane pick, then extend
    assign rawWord  = mem[wordIdx];
    assign loadByte = rawWord[{addr[1:0], 3'b000} +: 8];
    assign loadHalf = addr[1] ? rawWord[31:16] : rawWord[15:0];

    always_comb begin
        case (ctrl.memSize)
            cpuPkg::memByte: loaded = ctrl.memUnsigned ? {24'b0, loadByte}
                                                       : {{24{loadByte[7]}}, loadByte};
            cpuPkg::memHalf: loaded = ctrl.memUnsigned ? {16'b0, loadHalf}
                                                       : {{16{loadHalf[15]}}, loadHalf};
            default:         loaded = rawWord;
        endcase
    end

    assign rdata      = ctrl.memRead ? loaded : '0;
    assign hostRdData = mem[hostRdIdx];   // Host readback after halt

endmodule

/* hw/decoder.sv */
// Instruction decode
`timescale 1ns/10ps

module decoder (
    input  cpuPkg::word instr,
    output cpuPkg::ctrlSig ctrl
);

    localparam logic [6:0] OpReg    = 7'b0110011;
    localparam logic [6:0] OpImm    = 7'b0010011;
    localparam logic [6:0] OpLoad   = 7'b0000011;
    localparam logic [6:0] OpStore  = 7'b0100011;
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpJal    = 7'b1101111;
    localparam logic [6:0] OpLui    = 7'b0110111;
    localparam logic [6:0] OpSystem = 7'b1110011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    cpuPkg::word immI, immS, immB, immJ, immU;

    // funct3 plus bit 30 to ALU operation
    function automatic cpuPkg::aluOp pickOp(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  pickOp = alt ? cpuPkg::opSub : cpuPkg::opAdd;
            3'b001:  pickOp = cpuPkg::opSll;
            3'b010:  pickOp = cpuPkg::opSlt;
            3'b100:  pickOp = cpuPkg::opXor;
            3'b101:  pickOp = alt ? cpuPkg::opSra : cpuPkg::opSrl;
            3'b110:  pickOp = cpuPkg::opOr;
            3'b111:  pickOp = cpuPkg::opAnd;
            default: pickOp = cpuPkg::opAdd;   // sltu unsupported
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // I, S, B and J immediates sign extend from bit 31
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign immU = {instr[31:12], 12'b0};

    always_comb begin
        ctrl = '0;     // No-op unless recognized
        ctrl.memSize = funct3[1] ? cpuPkg::memWord :
                       (funct3[0] ? cpuPkg::memHalf : cpuPkg::memByte);
        ctrl.memUnsigned = funct3[2];
        case (opcode)
            OpReg: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = pickOp(funct3, instr[30]);
            end
            OpImm: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = pickOp(funct3, instr[30] & (funct3 == 3'b101)); // Only srai
                ctrl.imm       = immI;
            end
            OpLoad: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.aluSrcImm = 1'b1;         // Address rs1 plus offset
                ctrl.wbSel     = cpuPkg::wbMemData;
                ctrl.imm       = immI;
            end
            OpStore: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.imm       = immS;
            end
            OpBranch: begin
                ctrl.branch   = (funct3[2:1] == 2'b00);   // beq and bne only
                ctrl.branchNe = funct3[0];
                ctrl.aluOp    = cpuPkg::opSub;            // Compare via zero flag
                ctrl.imm      = immB;
            end
            OpJal: begin
                ctrl.regWrite = 1'b1;
                ctrl.jump     = 1'b1;
                ctrl.wbSel    = cpuPkg::wbLinkPc;
                ctrl.imm      = immJ;
            end
            OpLui: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = cpuPkg::opPassB;
                ctrl.imm       = immU;
            end
            OpSystem: begin
                ctrl.halt = (instr[31:7] == '0);   // ecall only
            end
            default: begin
            end
        endcase
    end

endmodule

/* hw/fetchUnit.sv */
// Program counter and instruction store
`timescale 1ns/10ps
`include "cpu_params.svh"

module fetchUnit #(
    parameter int WORDS = `CPU_IMEM_WORDS
) (
    input  logic clock,
    input  logic arstN,
    input  logic runEn,
    input  logic clearPc,
    input  logic progWe,
    input  logic [$clog2(WORDS)-1:0] progIdx,
    input  cpuPkg::word progData,
    input  cpuPkg::ctrlSig ctrl,
    input  logic zero,
    output cpuPkg::word instr,
    output cpuPkg::word pcNow,
    output cpuPkg::word retired
);

    localparam int IdxW = $clog2(WORDS);

    cpuPkg::word progMem [WORDS];
    cpuPkg::word pc, pcPlus4, pcTarget, pcNext;
    logic taken;
    logic advance;

    // Host-only write port
    always_ff @(posedge clock) begin
        if (progWe) begin
            progMem[progIdx] <= progData;
        end
    end

    assign instr = progMem[pc[IdxW+1:2]];   // Word index from byte PC
    assign pcNow = pc;

    // beq on zero, bne on nonzero
    assign taken    = ctrl.jump | (ctrl.branch & (zero ^ ctrl.branchNe));
    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + ctrl.imm;
    assign pcNext   = taken ? pcTarget : pcPlus4;
    assign advance  = runEn & ~ctrl.halt;    // ecall holds PC, not counted

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            pc      <= '0;
            retired <= '0;
        end else if (clearPc) begin
            pc      <= '0;
            retired <= '0;
        end else if (advance) begin
            pc      <= pcNext;
            retired <= retired + 32'd1;
        end
    end

    // Branch and jump offsets must keep word alignment
    assert property (@(posedge clock) disable iff (!arstN) pc[1:0] == 2'b00);

endmodule

/* hw/regFile.sv */
// Integer register file
`timescale 1ns/10ps

module regFile (
    input  logic clock,
    input  logic arstN,
    input  logic we,
    input  cpuPkg::regIdx rs1,
    input  cpuPkg::regIdx rs2,
    input  cpuPkg::regIdx rd,
    input  cpuPkg::word wd,
    output cpuPkg::word rd1,
    output cpuPkg::word rd2
);

    cpuPkg::word regs [32];

    // Asynchronous read ports
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin   // x0 write dropped
            regs[rd] <= wd;
        end
    end

    // x0 stays zero across every write-back
    assert property (@(posedge clock) disable iff (!arstN) regs[0] == '0);

endmodule

/* hw/runControl.sv */
// Host port and run control
`timescale 1ns/10ps
`include "cpu_params.svh"

module runControl (
    input  logic clock,
    input  logic arstN,
    input  cpuPkg::apbReq apbIn,
    input  logic haltReq,
    output cpuPkg::apbRsp apbOut,
    output logic runEn,
    output logic clearPc,
    output logic progWe,
    output logic [$clog2(`CPU_IMEM_WORDS)-1:0] progIdx,
    output cpuPkg::word progData,
    output logic [$clog2(`CPU_DMEM_WORDS)-1:0] hostRdIdx,
    input  cpuPkg::word retired,
    input  cpuPkg::word hostRdData
);

    localparam int AW = `CPU_APB_AW;
    localparam int IW = $clog2(`CPU_IMEM_WORDS);
    localparam int DW = $clog2(`CPU_DMEM_WORDS);
    localparam int ImemEnd = `CPU_IMEM_BASE + `CPU_IMEM_WORDS * 4;
    localparam int DmemEnd = `CPU_DMEM_BASE + `CPU_DMEM_WORDS * 4;
    localparam logic [AW-1:0] ImemBase = `CPU_IMEM_BASE;
    localparam logic [AW-1:0] DmemBase = `CPU_DMEM_BASE;

    typedef enum logic [1:0] {stIdle, stRun, stHalt} runState;

    runState state;
    logic setupPh, accessPh;
    logic running, halted;
    logic inImem, inDmem, isCtrl, isStatus, isRetired;
    logic [AW-1:0] imemOff, dmemOff;
    logic errNow, errQ;
    logic ctrlWrite, startReq;
    cpuPkg::word rdNow, rdQ;

    assign setupPh  = apbIn.psel & ~apbIn.penable;
    assign accessPh = apbIn.psel & apbIn.penable;
    assign running  = (state == stRun);
    assign halted   = (state == stHalt);

    // Address decode
    assign inImem    = (apbIn.paddr >= ImemBase) && (apbIn.paddr < ImemEnd);
    assign inDmem    = (apbIn.paddr >= DmemBase) && (apbIn.paddr < DmemEnd);
    assign isCtrl    = (apbIn.paddr == `CPU_ADDR_CTRL);
    assign isStatus  = (apbIn.paddr == `CPU_ADDR_STATUS);
    assign isRetired = (apbIn.paddr == `CPU_ADDR_RETIRED);
    assign imemOff   = apbIn.paddr - ImemBase;
    assign dmemOff   = apbIn.paddr - DmemBase;

    always_comb begin
        errNow = 1'b0;
        rdNow  = '0;     // CTRL and program window read back zero
        if (inImem) begin
            errNow = apbIn.pwrite & running;   // Program locked during a run
        end else if (inDmem) begin
            errNow = apbIn.pwrite | running;   // Read-only, and only when stopped
            rdNow  = hostRdData;
        end else if (isStatus) begin
            errNow = apbIn.pwrite;
            rdNow  = {{(`CPU_XLEN-2){1'b0}}, halted, running};
        end else if (isRetired) begin
            errNow = apbIn.pwrite;
            rdNow  = retired;
        end else if (!isCtrl) begin
            errNow = 1'b1;                     // Unmapped offset
        end
    end

    // Response captured in setup, presented in access
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            errQ <= 1'b0;
        end else if (setupPh) begin
            errQ <= errNow;
        end
    end

    always_ff @(posedge clock) begin
        if (setupPh) begin
            rdQ <= rdNow;
        end
    end

    assign apbOut.prdata  = rdQ;
    assign apbOut.pready  = accessPh;          // No wait states
    assign apbOut.pslverr = accessPh & errQ;

    // Host writes take effect at the access edge
    assign ctrlWrite = accessPh & apbIn.pwrite & isCtrl;
    assign startReq  = ctrlWrite & apbIn.pwdata[0] & ~running;
    assign clearPc   = ctrlWrite & apbIn.pwdata[1] & ~running;
    assign progWe    = accessPh & apbIn.pwrite & inImem & ~running;
    assign progIdx   = imemOff[IW+1:2];
    assign progData  = apbIn.pwdata;
    assign hostRdIdx = dmemOff[DW+1:2];
    assign runEn     = running;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            state <= stIdle;
        end else begin
            case (state)
                stRun: begin
                    if (haltReq) state <= stHalt;   // ecall in flight
                end
                default: begin
                    if (startReq) begin
                        state <= stRun;
                    end else if (clearPc) begin
                        state <= stIdle;            // Clear drops halted
                    end
                end
            endcase
        end
    end

    // APB access phase always follows a select
    assert property (@(posedge clock) disable iff (!arstN) apbIn.penable |-> apbIn.psel);

endmodule

/* list.f */
+incdir+hw
+incdir+sim
hw/cpuPkg.sv
hw/alu.sv
hw/regFile.sv
hw/decoder.sv
hw/dataMem.sv
hw/fetchUnit.sv
hw/runControl.sv
hw/cpuTop.sv
sim/cpuTb.sv

/* sim/cpuTbTable.svh */
// Test programs and expected results
`ifndef CPU_TB_TABLE_SVH
`define CPU_TB_TABLE_SVH

localparam logic [6:0] opcReg    = 7'b0110011;
localparam logic [6:0] opcImm    = 7'b0010011;
localparam logic [6:0] opcLoad   = 7'b0000011;
localparam logic [6:0] opcStore  = 7'b0100011;
localparam logic [6:0] opcBranch = 7'b1100011;
localparam logic [6:0] opcJal    = 7'b1101111;
localparam logic [6:0] opcLui    = 7'b0110111;
localparam cpuPkg::word EcallWord = 32'h00000073;
localparam int LoopCount = 1000;   // Long loop for run-time probes

// One row per program
typedef struct packed {
    int progFirst;     // Index into progWords
    int progLen;
    int chkFirst;      // Index into chkAddr and chkValue
    int chkCount;
    int expRetired;
    logic probeRun;    // Error probes while running
} testRow;

cpuPkg::word progWords[$];
logic [11:0] chkAddr[$];     // Data memory byte address
cpuPkg::word chkValue[$];
testRow tests[$];
testRow cur;
logic [11:0] slotAddr;

function automatic cpuPkg::word rFormat(input logic [6:0] f7, input cpuPkg::regIdx rs2,
                                        input cpuPkg::regIdx rs1, input logic [2:0] f3,
                                        input cpuPkg::regIdx rd);
    return {f7, rs2, rs1, f3, rd, opcReg};
endfunction

function automatic cpuPkg::word iFormat(input logic [11:0] imm, input cpuPkg::regIdx rs1,
                                        input logic [2:0] f3, input cpuPkg::regIdx rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

// rs1 is the base, rs2 the data
function automatic cpuPkg::word sFormat(input logic [11:0] imm, input cpuPkg::regIdx rs1,
                                        input cpuPkg::regIdx rs2, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opcStore};
endfunction

function automatic cpuPkg::word bFormat(input logic [12:0] imm, input cpuPkg::regIdx rs1,
                                        input cpuPkg::regIdx rs2, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opcBranch};
endfunction

function automatic cpuPkg::word jFormat(input logic [20:0] imm, input cpuPkg::regIdx rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opcJal};
endfunction

function automatic cpuPkg::word uFormat(input logic [19:0] imm, input cpuPkg::regIdx rd);
    return {imm, rd, opcLui};
endfunction

function automatic cpuPkg::word sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

// Words emitted so far in this program
function automatic int straightCount();
    return progWords.size() - cur.progFirst;
endfunction

task automatic emit(input cpuPkg::word w);
    progWords.push_back(w);
endtask

task automatic expectWord(input logic [11:0] addr, input cpuPkg::word value);
    chkAddr.push_back(addr);
    chkValue.push_back(value);
endtask

task automatic storeCheck(input cpuPkg::regIdx rs, input logic [11:0] addr,
                          input cpuPkg::word value);
    emit(sFormat(addr, 5'd0, rs, 3'b010));   // sw rs, addr(x0)
    expectWord(addr, value);
endtask

task automatic storeNext(input cpuPkg::regIdx rs, input cpuPkg::word value);
    storeCheck(rs, slotAddr, value);
    slotAddr = slotAddr + 12'd4;
endtask

task automatic aluReg(input logic [6:0] f7, input logic [2:0] f3, input cpuPkg::word value);
    emit(rFormat(f7, 5'd2, 5'd1, f3, 5'd3));   // x3 = x1 op x2
    storeNext(5'd3, value);
endtask

task automatic aluImm(input logic [2:0] f3, input logic [11:0] imm, input cpuPkg::regIdx rs,
                      input cpuPkg::word value);
    emit(iFormat(imm, rs, f3, 5'd3, opcImm));
    storeNext(5'd3, value);
endtask

// Load into x4, then store x4 out
task automatic loadCheck(input logic [2:0] f3, input logic [11:0] from, input logic [11:0] to,
                         input cpuPkg::word value);
    emit(iFormat(from, 5'd0, f3, 5'd4, opcLoad));
    storeCheck(5'd4, to, value);
endtask

task automatic openTest();
    cur = '0;
    cur.progFirst = progWords.size();
    cur.chkFirst = chkAddr.size();
endtask

task automatic closeTest(input int retired, input logic probe);
    emit(EcallWord);   // Halts, not counted
    cur.progLen = straightCount();
    cur.chkCount = chkAddr.size() - cur.chkFirst;
    cur.expRetired = retired;
    cur.probeRun = probe;
    tests.push_back(cur);
endtask

`endif

/* sim/cpuTb.sv */
// Core testbench
`timescale 1ns/10ps
`include "cpu_params.svh"

module cpuTb;

    localparam logic [11:0] CtrlAddr    = `CPU_ADDR_CTRL;
    localparam logic [11:0] StatusAddr  = `CPU_ADDR_STATUS;
    localparam logic [11:0] RetiredAddr = `CPU_ADDR_RETIRED;
    localparam logic [11:0] ImemBase    = `CPU_IMEM_BASE;
    localparam logic [11:0] DmemBase    = `CPU_DMEM_BASE;
    localparam int HaltPolls = 3000;   // STATUS reads before giving up

    logic clock;
    logic arstN;
    cpuPkg::apbReq apbIn;
    cpuPkg::apbRsp apbOut;

    `include "cpuTbTable.svh"

    cpuTop uut (.clock(clock), .arstN(arstN), .apbIn(apbIn), .apbOut(apbOut));

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkWord(input string name, input cpuPkg::word got, input cpuPkg::word exp);
        if (got !== exp) begin
            failRun($sformatf("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    // Compares pready and pslverr only
    task automatic checkRsp(input string name, input cpuPkg::apbRsp got,
                            input cpuPkg::apbRsp exp);
        if (got.pready !== exp.pready || got.pslverr !== exp.pslverr) begin
            failRun($sformatf("[FAIL] %s pready,pslverr got 0x%0h,0x%0h expected 0x%0h,0x%0h",
                              name, got.pready, got.pslverr, exp.pready, exp.pslverr));
        end
    endtask

    // Setup phase then access phase on falling edges
    task automatic busCycle(input logic [11:0] addr, input logic write, input cpuPkg::word wdata,
                            input logic expErr, output cpuPkg::word rdata);
        cpuPkg::apbRsp rsp;
        cpuPkg::apbRsp expRsp;
        @(negedge clock);
        apbIn.paddr   = addr;
        apbIn.psel    = 1'b1;
        apbIn.penable = 1'b0;
        apbIn.pwrite  = write;
        apbIn.pwdata  = wdata;
        @(negedge clock);
        apbIn.penable = 1'b1;
        @(negedge clock);
        rsp = apbOut;            // Access phase still held
        apbIn.psel    = 1'b0;
        apbIn.penable = 1'b0;
        expRsp = rsp;
        expRsp.pready  = 1'b1;
        expRsp.pslverr = expErr;
        checkRsp($sformatf("apb 0x%03h", addr), rsp, expRsp);
        rdata = rsp.prdata;
    endtask

    task automatic apbWrite(input logic [11:0] addr, input cpuPkg::word data, input logic expErr);
        cpuPkg::word unused;
        busCycle(addr, 1'b1, data, expErr, unused);
    endtask

    task automatic apbRead(input logic [11:0] addr, input logic expErr,
                           output cpuPkg::word data);
        busCycle(addr, 1'b0, '0, expErr, data);
    endtask

    task automatic waitHalted();
        cpuPkg::word status;
        int polls;
        status = '0;
        polls = 0;
        while (status[1] !== 1'b1) begin
            if (polls == HaltPolls) begin
                failRun("core did not halt within the STATUS poll limit");
            end
            apbRead(StatusAddr, 1'b0, status);
            polls++;
        end
        checkWord("STATUS", status, 32'h2);   // Halted, not running
    endtask

    task automatic buildTables();
        cpuPkg::word a;
        cpuPkg::word b;
        cpuPkg::word rnd;
        logic [11:0] r1;
        logic [11:0] r2;
        cpuPkg::word linkPc;
        // Arithmetic and logic with results stored from 0x000 up
        openTest();
        slotAddr = 12'h000;
        a = 32'hF0F0F0A5;                     // Negative operand
        b = 32'h12345678;                     // Shift amount 24
        emit(uFormat(20'hF0F0F, 5'd1));
        emit(iFormat(12'h0A5, 5'd1, 3'b000, 5'd1, opcImm));
        emit(uFormat(20'h12345, 5'd2));
        emit(iFormat(12'h678, 5'd2, 3'b000, 5'd2, opcImm));
        aluReg(7'h00, 3'b000, a + b);
        aluReg(7'h20, 3'b000, a - b);
        aluReg(7'h00, 3'b111, a & b);
        aluReg(7'h00, 3'b110, a | b);
        aluReg(7'h00, 3'b100, a ^ b);
        aluReg(7'h00, 3'b010, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        aluReg(7'h00, 3'b001, a << b[4:0]);
        aluReg(7'h00, 3'b101, a >> b[4:0]);
        aluReg(7'h20, 3'b101, $signed(a) >>> b[4:0]);
        aluImm(3'b000, 12'hFFB, 5'd1, a + sext12(12'hFFB));
        aluImm(3'b111, 12'h7F0, 5'd1, a & 32'h7F0);
        aluImm(3'b110, 12'hF00, 5'd2, b | sext12(12'hF00));
        aluImm(3'b100, 12'h555, 5'd2, b ^ 32'h555);
        aluImm(3'b010, 12'hFFF, 5'd1, ($signed(a) < -1) ? 32'd1 : 32'd0);
        aluImm(3'b010, 12'hFFF, 5'd2, ($signed(b) < -1) ? 32'd1 : 32'd0);
        aluImm(3'b001, 12'h004, 5'd2, b << 4);
        aluImm(3'b101, 12'h008, 5'd1, a >> 8);
        aluImm(3'b101, 12'h408, 5'd1, $signed(a) >>> 8);   // srai, bit 30 set
        rnd = $urandom;
        r1 = rnd[11:0];
        rnd = $urandom;
        r2 = rnd[11:0];
        emit(iFormat(r1, 5'd0, 3'b000, 5'd4, opcImm));
        emit(iFormat(r2, 5'd0, 3'b000, 5'd5, opcImm));
        emit(rFormat(7'h00, 5'd5, 5'd4, 3'b000, 5'd6));
        storeNext(5'd6, sext12(r1) + sext12(r2));
        closeTest(straightCount(), 1'b0);

        // Byte and half stores into 0x100 and loads read back
        openTest();
        emit(iFormat(12'h084, 5'd0, 3'b000, 5'd1, opcImm));
        emit(iFormat(12'h07E, 5'd0, 3'b000, 5'd2, opcImm));
        emit(uFormat(20'h0000C, 5'd3));
        emit(iFormat(12'hEEF, 5'd3, 3'b000, 5'd3, opcImm));   // x3 = 0xBEEF
        emit(sFormat(12'h100, 5'd0, 5'd1, 3'b000));
        emit(sFormat(12'h101, 5'd0, 5'd2, 3'b000));
        emit(sFormat(12'h102, 5'd0, 5'd3, 3'b001));
        expectWord(12'h100, 32'hBEEF7E84);                     // Little-endian lanes
        loadCheck(3'b000, 12'h100, 12'h104, 32'hFFFFFF84);
        loadCheck(3'b100, 12'h100, 12'h108, 32'h00000084);
        loadCheck(3'b000, 12'h101, 12'h10C, 32'h0000007E);
        loadCheck(3'b001, 12'h102, 12'h110, 32'hFFFFBEEF);
        loadCheck(3'b101, 12'h102, 12'h114, 32'h0000BEEF);
        loadCheck(3'b010, 12'h100, 12'h118, 32'hBEEF7E84);
        loadCheck(3'b100, 12'h103, 12'h11C, 32'h000000BE);
        loadCheck(3'b001, 12'h100, 12'h120, 32'h00007E84);
        closeTest(straightCount(), 1'b0);

        // Countdown loop, beq both ways and a jal link
        openTest();
        emit(iFormat(12'd5, 5'd0, 3'b000, 5'd1, opcImm));
        emit(iFormat(12'd0, 5'd0, 3'b000, 5'd2, opcImm));
        emit(iFormat(12'd3, 5'd2, 3'b000, 5'd2, opcImm));     // Loop top
        emit(iFormat(12'hFFF, 5'd1, 3'b000, 5'd1, opcImm));
        emit(bFormat(13'h1FF8, 5'd1, 5'd0, 3'b001));          // bne back 8
        storeCheck(5'd1, 12'h200, 32'd0);
        storeCheck(5'd2, 12'h204, 32'd15);                     // 5 passes of 3
        emit(bFormat(13'd8, 5'd0, 5'd0, 3'b000));             // Taken
        emit(iFormat(12'd99, 5'd0, 3'b000, 5'd2, opcImm));
        emit(bFormat(13'd8, 5'd2, 5'd0, 3'b000));             // Not taken
        emit(iFormat(12'd7, 5'd0, 3'b000, 5'd3, opcImm));
        storeCheck(5'd3, 12'h208, 32'd7);
        linkPc = 4 * straightCount() + 4;
        emit(jFormat(21'd8, 5'd5));
        emit(iFormat(12'd1, 5'd0, 3'b000, 5'd2, opcImm));     // Jumped over
        storeCheck(5'd5, 12'h20C, linkPc);
        storeCheck(5'd2, 12'h210, 32'd15);
        closeTest(26, 1'b0);   // 2 + 15 in loop + 9 after

        // Long loop for probes while running
        openTest();
        emit(iFormat(LoopCount[11:0], 5'd0, 3'b000, 5'd1, opcImm));
        emit(iFormat(12'hFFF, 5'd1, 3'b000, 5'd1, opcImm));
        emit(bFormat(13'h1FFC, 5'd1, 5'd0, 3'b001));
        emit(iFormat(12'h055, 5'd0, 3'b000, 5'd2, opcImm));
        storeCheck(5'd2, 12'h300, 32'h55);
        closeTest(1 + 2 * LoopCount + 2, 1'b1);
    endtask

    // Host accesses that must fail during a run
    task automatic probeWhileRunning();
        cpuPkg::word value;
        apbWrite(ImemBase + 12'd12, EcallWord, 1'b1);   // Would cut the program short
        apbRead(StatusAddr, 1'b0, value);
        checkWord("STATUS", value, 32'h1);
        apbRead(DmemBase + 12'h300, 1'b1, value);
        apbRead(12'h00C, 1'b1, value);
        apbRead(12'hC00, 1'b1, value);                  // Past data window
        apbWrite(StatusAddr, 32'h0, 1'b1);
        apbWrite(RetiredAddr, 32'h0, 1'b1);
        apbRead(RetiredAddr, 1'b0, value);
    endtask

    task automatic runTest(input testRow row);
        cpuPkg::word value;
        apbWrite(CtrlAddr, 32'h2, 1'b0);   // Clear PC and count
        for (int i = 0; i < row.progLen; i++) begin
            apbWrite(ImemBase + 12'(4 * i), progWords[row.progFirst + i], 1'b0);
        end
        apbWrite(CtrlAddr, 32'h1, 1'b0);
        if (row.probeRun) begin
            probeWhileRunning();
        end
        waitHalted();
        apbRead(RetiredAddr, 1'b0, value);
        checkWord("RETIRED", value, row.expRetired);
        for (int k = row.chkFirst; k < row.chkFirst + row.chkCount; k++) begin
            apbRead(DmemBase + chkAddr[k], 1'b0, value);
            checkWord($sformatf("dmem 0x%03h", chkAddr[k]), value, chkValue[k]);
        end
    endtask

    // Clear holds the core idle until the next start
    task automatic checkRestart(input testRow row);
        cpuPkg::word value;
        apbWrite(CtrlAddr, 32'h2, 1'b0);
        apbRead(StatusAddr, 1'b0, value);
        checkWord("STATUS", value, 32'h0);
        apbRead(RetiredAddr, 1'b0, value);
        checkWord("RETIRED", value, 32'h0);
        repeat (20) @(negedge clock);
        apbRead(RetiredAddr, 1'b0, value);
        checkWord("RETIRED", value, 32'h0);
        apbRead(CtrlAddr, 1'b0, value);
        checkWord("CTRL", value, 32'h0);
        apbWrite(CtrlAddr, 32'h1, 1'b0);
        waitHalted();
        apbRead(RetiredAddr, 1'b0, value);
        checkWord("RETIRED", value, row.expRetired);
    endtask

    initial begin
        arstN = 1'b0;
        apbIn = '0;
        void'($urandom(85702));
        buildTables();
        repeat (8) @(posedge clock);
        @(negedge clock);
        arstN = 1'b1;
        for (int t = 0; t < tests.size(); t++) begin
            runTest(tests[t]);
        end
        checkRestart(tests[tests.size() - 1]);
        $display("all tests passed");
        $finish;
    end

endmodule
